// File: bench/exec_core_props.sv
// Concurrent checks on strobe timing and flag rules, bound into every exec_core instance
`timescale 1ns/10ps
`default_nettype none

module exec_core_props (
	input wire logic             clk_i,
	input wire logic             arst_n_i,
	input wire logic             instr_valid_i,
	input wire alu_pkg::word_t   result_i,
	input wire logic             zf_i,
	input wire logic             lt_i,
	input wire logic             result_valid_i,
	input wire alu_pkg::alu_op_e res_op_i // Operation behind result_i
);
	import alu_pkg::*;

	// Outputs held clear while reset is applied
	assert property (@(posedge clk_i) !arst_n_i |->
			!result_valid_i && result_i == '0 && !zf_i && !lt_i)
		else $error("Outputs not clear during reset");

	// Strobe exactly one cycle after each accept
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
			instr_valid_i |=> result_valid_i)
		else $error("Result strobe missing after an accepted instruction");
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
			!instr_valid_i |=> !result_valid_i)
		else $error("Result strobe without an accepted instruction");

	assert property (@(posedge clk_i) disable iff (!arst_n_i)
			result_valid_i |-> zf_i == (result_i == '0))
		else $error("Zero flag does not match the result");

	// Less-than only for the ordering compares
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
			result_valid_i && res_op_i != ALU_SLT && res_op_i != ALU_SLE |-> !lt_i)
		else $error("Less-than flag high on a non-ordering operation");
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
			result_valid_i && (res_op_i == ALU_SLT || res_op_i == ALU_SLE) |->
			lt_i == result_i[0])
		else $error("Less-than flag differs from the compare result");

endmodule

bind exec_core exec_core_props i_props (
	.clk_i          (clk_i),
	.arst_n_i       (arst_n_i),
	.instr_valid_i  (instr_valid_i),
	.result_i       (result_o),
	.zf_i           (zf_o),
	.lt_i           (lt_o),
	.result_valid_i (result_valid_o),
	.res_op_i       (res_op_q)
);

`default_nettype wire

// File: bench/exec_core_tb.sv
// Testbench of the execute stage, runs directed and random instructions against a register model
`timescale 1ns/10ps
`default_nettype none

module exec_core_tb;
	import alu_pkg::*;
	import isa_pkg::*;

	localparam int RESULT_WAIT = 8; // Cycles before a missing strobe counts as lost

	logic        clk = 1'b0;
	logic        arst_n;
	logic        instr_valid;
	instr_u      instr;
	word_t       result;
	logic        zf;
	logic        lt;
	logic        result_valid;
	word_t       model_regs [8]; // Expected register contents
	int unsigned n_accepted;     // Instructions taken so far
	int unsigned errors;
	int unsigned timeouts;
	logic [31:0] rng = 32'hdc1b;

	always #2 clk = ~clk; // 4 ns period

	exec_core i_dut (
		.clk_i          (clk),
		.arst_n_i       (arst_n),
		.instr_valid_i  (instr_valid),
		.instr_i        (instr),
		.result_o       (result),
		.zf_o           (zf),
		.lt_o           (lt),
		.result_valid_o (result_valid)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Reference rules for the sixteen operations
	function automatic word_t expect_result(input alu_op_e op, input word_t a, input word_t b,
			input word_t pc2);
		logic [31:0] dbl;  // A twice, for rotates
		logic [16:0] wide; // A + B with carry
		word_t       rev;
		dbl  = {a, a};
		wide = {1'b0, a} + {1'b0, b};
		for (int k = 0; k < 16; k++) begin
			rev[k] = a[15-k];
		end
		case (op)
			ALU_ADD:   return a + b;
			ALU_SUB:   return b - a;
			ALU_XOR:   return a ^ b;
			ALU_ANDN:  return a & ~b;
			ALU_ROL:   return word_t'((dbl << b[3:0]) >> 16); // Upper half after the move
			ALU_SLL:   return a << b[3:0];
			ALU_ROR:   return word_t'(dbl >> b[3:0]);
			ALU_SRL:   return a >> b[3:0];
			ALU_SEQ:   return word_t'(a == b);
			ALU_SLT:   return word_t'($signed(a) < $signed(b));
			ALU_SLE:   return word_t'($signed(a) <= $signed(b));
			ALU_SCO:   return word_t'(wide[16]);
			ALU_REV:   return rev;
			ALU_PASSB: return b;
			ALU_MOVB:  return {a[7:0], b[7:0]};
			default:   return pc2;
		endcase
	endfunction

	function automatic instr_u reg_instr(input alu_op_e op, input reg_addr_t rd, rs, rt);
		return {FMT_REG, op, rd, rs, rt, 2'b00};
	endfunction

	function automatic instr_u imm_instr(input alu_op_e op, input reg_addr_t rd, input imm_t imm);
		return {FMT_IMM, op, rd, imm};
	endfunction

	task automatic compare(input string name, input word_t got, input word_t want);
		assert (got == want) else begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) @(negedge clk);
	endtask

	// Drive one instruction, then check its result one cycle later
	task automatic execute(input instr_u ins);
		alu_op_e   op;
		reg_addr_t rd;
		word_t     a;
		word_t     b;
		word_t     want;
		int        waited;
		op = alu_op_e'(ins.r.op);
		if (ins.r.fmt == FMT_IMM) begin
			rd = ins.i.rd;
			a  = model_regs[ins.i.rd]; // Destination is also A
			b  = {8'h00, ins.i.imm};
		end else begin
			rd = ins.r.rd;
			a  = model_regs[ins.r.rs];
			b  = model_regs[ins.r.rt];
		end
		want        = expect_result(op, a, b, word_t'(2 * n_accepted + 2));
		instr       = ins;
		instr_valid = 1'b1;
		@(posedge clk);
		model_regs[rd] = want; // Written on the accepting edge
		n_accepted++;
		@(negedge clk);
		instr_valid = 1'b0; // Next call may raise it again at once
		waited      = 0;
		while (!result_valid && waited < RESULT_WAIT) begin
			@(negedge clk);
			waited++;
		end
		if (!result_valid) begin
			timeouts++;
			$display("No result strobe within %0d cycles for instruction %h", RESULT_WAIT, ins);
		end else begin
			compare("result_o", result, want);
			compare("zf_o", word_t'(zf), word_t'(want == '0));
			compare("lt_o", word_t'(lt), word_t'((op == ALU_SLT || op == ALU_SLE) ? want[0] : 1'b0));
		end
	endtask

	initial begin
		arst_n      = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		errors      = 0;
		timeouts    = 0;
		n_accepted  = 0;
		model_regs  = '{default: '0};
		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		compare("result_valid_o", word_t'(result_valid), '0); // Idle after reset
		compare("result_o", result, '0);
		compare("zf_o", word_t'(zf), '0);
		compare("lt_o", word_t'(lt), '0);
		for (int r = 0; r < 8; r++) begin
			execute(reg_instr(ALU_PASSB, reg_addr_t'(r), reg_addr_t'(r), reg_addr_t'(r)));
		end
		// Known values built from two immediate halves
		for (int r = 0; r < 8; r++) begin
			rng = xorshift(rng);
			execute(imm_instr(ALU_PASSB, reg_addr_t'(r), rng[7:0]));
			execute(imm_instr(ALU_MOVB, reg_addr_t'(r), rng[15:8]));
		end
		// Data ops, each followed by a dependent XOR
		for (int k = 0; k < 13; k++) begin
			if (k < 8 || k == 12) begin
				rng = xorshift(rng);
				execute(reg_instr(alu_op_e'(k[3:0]), rng[2:0], rng[5:3], rng[8:6]));
				execute(reg_instr(ALU_XOR, rng[11:9], rng[2:0], rng[14:12]));
			end
		end
		execute(imm_instr(ALU_PASSB, 3'd0, 8'h80));
		execute(imm_instr(ALU_MOVB, 3'd0, 8'h00));      // r0 = 8000
		execute(imm_instr(ALU_PASSB, 3'd1, 8'hff));
		execute(imm_instr(ALU_MOVB, 3'd1, 8'hff));      // r1 = ffff
		execute(imm_instr(ALU_PASSB, 3'd2, 8'h01));     // r2 = 0001
		execute(reg_instr(ALU_PASSB, 3'd3, 3'd0, 3'd0)); // r3 equal to r0
		for (int k = 8; k < 12; k++) begin // Compares and carry on every pair
			for (int a = 0; a < 4; a++) begin
				for (int b = 0; b < 4; b++) begin
					execute(reg_instr(alu_op_e'(k[3:0]), 3'd7, reg_addr_t'(a), reg_addr_t'(b)));
				end
			end
		end
		repeat (300) begin // Random words, both formats, with idle gaps
			rng = xorshift(rng);
			execute(rng[15:0]);
			if (rng[20:19] == 2'b00) begin
				idle(1 + rng[23:22]);
			end
		end
		execute(reg_instr(ALU_PC2, 3'd5, 3'd0, 3'd0));
		@(negedge clk);
		$display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: exec_core.f
hw/alu_pkg.sv
hw/isa_pkg.sv
hw/alu_shifter.sv
hw/alu_cla.sv
hw/alu.sv
hw/inst_decode.sv
hw/reg_file.sv
hw/exec_core.sv
bench/exec_core_props.sv
bench/exec_core_tb.sv

// File: hw/alu.sv
// Combinational sixteen-operation ALU with zero and less-than flags for exec_core
`timescale 1ns/10ps
`default_nettype none

module alu (
	input  wire alu_pkg::word_t   a_i,
	input  wire alu_pkg::word_t   b_i,
	input  wire alu_pkg::word_t   pc2_i,    // Next instruction address
	input  wire alu_pkg::alu_op_e op_i,
	output alu_pkg::word_t        result_o,
	output logic                  lt_o,     // Ordering compares only
	output logic                  zf_o
);
	import alu_pkg::*;

	word_t add_a;     // Steered adder inputs
	word_t add_b;
	logic  add_ci;
	word_t add_sum;
	logic  add_co;
	word_t shift_out;
	logic  a_eq_b;
	logic  a_lt_b;    // Signed A < B

	alu_cla i_cla (
		.a_i   (add_a),
		.b_i   (add_b),
		.c_i   (add_ci),
		.sum_o (add_sum),
		.c_o   (add_co)
	);

	alu_shifter i_shifter (
		.in_i    (a_i),
		.shamt_i (shamt_t'(b_i[SHAMT_W-1:0])), // Low bits of B
		.op_i    (op_i[1:0]),                  // Direction and fill
		.out_o   (shift_out)
	);

	always_comb begin
		add_a  = a_i; // Plain A + B by default
		add_b  = b_i;
		add_ci = 1'b0;
		case (op_i)
			ALU_SUB: begin // B + ~A + 1
				add_a  = b_i;
				add_b  = ~a_i;
				add_ci = 1'b1;
			end
			ALU_SLT, ALU_SLE: begin // A + ~B + 1
				add_b  = ~b_i;
				add_ci = 1'b1;
			end
			default: ; // Plain add
		endcase
	end

	assign a_eq_b = (a_i == b_i);
	// Differing signs decide alone
	// Equal signs cannot overflow the difference
	assign a_lt_b = (a_i[WORD_W-1] != b_i[WORD_W-1]) ? a_i[WORD_W-1] : add_sum[WORD_W-1];

	always_comb begin
		case (op_i)
			ALU_ADD, ALU_SUB: result_o = add_sum;
			ALU_XOR:          result_o = a_i ^ b_i;
			ALU_ANDN:         result_o = a_i & ~b_i;
			ALU_ROL, ALU_SLL,
			ALU_ROR, ALU_SRL: result_o = shift_out; // Op bits pick direction and fill
			ALU_SEQ:          result_o = word_t'(a_eq_b);
			ALU_SLT:          result_o = word_t'(a_lt_b);
			ALU_SLE:          result_o = word_t'(a_lt_b | a_eq_b);
			ALU_SCO:          result_o = word_t'(add_co);
			ALU_REV:          result_o = {<<{a_i}}; // Bit 15 swaps with bit 0
			ALU_PASSB:        result_o = b_i;
			ALU_MOVB:         result_o = {a_i[7:0], b_i[7:0]};
			default:          result_o = pc2_i; // PC plus two
		endcase
	end

	always_comb begin
		case (op_i)
			ALU_SLT: lt_o = a_lt_b;
			ALU_SLE: lt_o = a_lt_b | a_eq_b;
			default: lt_o = 1'b0; // Not an ordering compare
		endcase
	end

	assign zf_o = (result_o == '0);

endmodule

`default_nettype wire

// File: hw/alu_cla.sv
// Two-level carry-lookahead adder of the ALU, four groups of four bits with carry out
`timescale 1ns/10ps
`default_nettype none

module alu_cla (
	input  wire alu_pkg::word_t a_i,
	input  wire alu_pkg::word_t b_i,
	input  wire logic           c_i,   // Carry in, set for subtract
	output alu_pkg::word_t      sum_o,
	output logic                c_o    // Carry out of bit 15
);
	import alu_pkg::*;

	word_t      g;     // Bit generate
	word_t      p;     // Bit propagate
	logic [3:0] grp_g; // Group generate
	logic [3:0] grp_p; // Group propagate
	logic [4:0] gc;    // Carry into each group

	assign g = a_i & b_i;
	assign p = a_i ^ b_i;

	for (genvar k = 0; k < 4; k++) begin : g_grp
		logic [3:0] gb;  // Group slice of g
		logic [3:0] pb;  // Group slice of p
		logic [3:0] cin; // Carry into each bit

		assign gb = g[4*k +: 4];
		assign pb = p[4*k +: 4];

		// Lookahead inside the group
		assign cin[0] = gc[k];
		assign cin[1] = gb[0] | (pb[0] & gc[k]);
		assign cin[2] = gb[1] | (pb[1] & gb[0]) | (pb[1] & pb[0] & gc[k]);
		assign cin[3] = gb[2] | (pb[2] & gb[1]) | (pb[2] & pb[1] & gb[0])
			| (pb[2] & pb[1] & pb[0] & gc[k]);

		assign grp_g[k] = gb[3] | (pb[3] & gb[2]) | (pb[3] & pb[2] & gb[1])
			| (pb[3] & pb[2] & pb[1] & gb[0]);
		assign grp_p[k] = &pb;

		assign sum_o[4*k +: 4] = pb ^ cin;
	end

	// Lookahead across groups
	assign gc[0] = c_i;
	assign gc[1] = grp_g[0] | (grp_p[0] & c_i);
	assign gc[2] = grp_g[1] | (grp_p[1] & grp_g[0]) | (grp_p[1] & grp_p[0] & c_i);
	assign gc[3] = grp_g[2] | (grp_p[2] & grp_g[1]) | (grp_p[2] & grp_p[1] & grp_g[0])
		| (grp_p[2] & grp_p[1] & grp_p[0] & c_i);
	assign gc[4] = grp_g[3] | (grp_p[3] & grp_g[2]) | (grp_p[3] & grp_p[2] & grp_g[1])
		| (grp_p[3] & grp_p[2] & grp_p[1] & grp_g[0])
		| (grp_p[3] & grp_p[2] & grp_p[1] & grp_p[0] & c_i);

	assign c_o = gc[4];

endmodule

`default_nettype wire

// File: hw/alu_pkg.sv
// ALU operation codes and data word types, imported by every datapath module
`default_nettype none

package alu_pkg;

	localparam int WORD_W  = 16; // Data path width
	localparam int SHAMT_W = 4;  // Enough for 0..15

	typedef logic [WORD_W-1:0]  word_t;  // Data word
	typedef logic [SHAMT_W-1:0] shamt_t; // Shift amount

	typedef enum logic [3:0] {
		ALU_ADD   = 4'h0, // A + B
		ALU_SUB   = 4'h1, // B - A
		ALU_XOR   = 4'h2, // A ^ B
		ALU_ANDN  = 4'h3, // A & ~B
		ALU_ROL   = 4'h4, // Rotate A left
		ALU_SLL   = 4'h5, // Shift A left
		ALU_ROR   = 4'h6, // Rotate A right
		ALU_SRL   = 4'h7, // Shift A right, zero fill
		ALU_SEQ   = 4'h8, // A == B
		ALU_SLT   = 4'h9, // A < B signed
		ALU_SLE   = 4'ha, // A <= B signed
		ALU_SCO   = 4'hb, // Carry of A + B
		ALU_REV   = 4'hc, // Bit reverse of A
		ALU_PASSB = 4'hd, // B
		ALU_MOVB  = 4'he, // {A[7:0], B[7:0]}
		ALU_PC2   = 4'hf  // Program counter plus two
	} alu_op_e;

endpackage

`default_nettype wire

// File: hw/alu_shifter.sv
// Log-depth rotator and logical shifter used by the ALU for its four shift operations
`timescale 1ns/10ps
`default_nettype none

module alu_shifter (
	input  wire alu_pkg::word_t  in_i,    // Word to move
	input  wire alu_pkg::shamt_t shamt_i, // Distance 0..15
	input  wire logic [1:0]      op_i,    // Bit 1 right, bit 0 zero fill
	output alu_pkg::word_t       out_o
);
	import alu_pkg::*;

	word_t stage [SHAMT_W+1]; // Word after each stage

	// One stage moving by a fixed power of two
	function automatic word_t move(input word_t d, input int unsigned n,
			input logic right, input logic fill_zero);
		word_t main_part;
		word_t wrap_part;
		if (right) begin
			main_part = d >> n;
			wrap_part = d << (WORD_W - n); // Low bits wrap to the top
		end else begin
			main_part = d << n;
			wrap_part = d >> (WORD_W - n); // High bits wrap to the bottom
		end
		return fill_zero ? main_part : (main_part | wrap_part);
	endfunction

	always_comb begin
		stage[0] = in_i;
		for (int k = 0; k < SHAMT_W; k++) begin // Stages of 1, 2, 4 and 8
			if (shamt_i[k]) begin
				stage[k+1] = move(stage[k], 1 << k, op_i[1], op_i[0]);
			end else begin
				stage[k+1] = stage[k]; // Bypass this stage
			end
		end
	end

	assign out_o = stage[SHAMT_W];

endmodule

`default_nettype wire

// File: hw/exec_core.sv
// Top level of the execute stage, decodes, executes and writes back one instruction per strobe
`timescale 1ns/10ps
`default_nettype none

module exec_core (
	input  wire logic            clk_i,
	input  wire logic            arst_n_i,
	input  wire logic            instr_valid_i,  // Accept instr_i this edge
	input  wire isa_pkg::instr_u instr_i,
	output alu_pkg::word_t       result_o,
	output logic                 zf_o,
	output logic                 lt_o,
	output logic                 result_valid_o  // One cycle after accept
);
	import alu_pkg::*;
	import isa_pkg::*;

	alu_op_e   dec_op;
	reg_addr_t dec_ra;
	reg_addr_t dec_rb;
	reg_addr_t dec_rd;
	logic      dec_use_imm;
	word_t     dec_imm;
	word_t     rf_a;        // Operand A
	word_t     rf_b;        // Register B before the immediate mux
	word_t     opnd_b;
	word_t     pc_q;        // Address of the current instruction
	word_t     pc2;
	word_t     alu_result;
	logic      alu_zf;
	logic      alu_lt;
	alu_op_e   res_op_q;    // Operation behind result_o

	inst_decode i_decode (
		.instr_i   (instr_i),
		.op_o      (dec_op),
		.ra_o      (dec_ra),
		.rb_o      (dec_rb),
		.rd_o      (dec_rd),
		.use_imm_o (dec_use_imm),
		.imm_o     (dec_imm)
	);

	reg_file i_regs (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.we_i     (instr_valid_i), // Write back on the accepting edge
		.wa_i     (dec_rd),
		.ra_i     (dec_ra),
		.rb_i     (dec_rb),
		.wd_i     (alu_result),
		.rda_o    (rf_a),
		.rdb_o    (rf_b)
	);

	assign opnd_b = dec_use_imm ? dec_imm : rf_b;
	assign pc2    = pc_q + word_t'(2);

	alu i_alu (
		.a_i      (rf_a),
		.b_i      (opnd_b),
		.pc2_i    (pc2),
		.op_i     (dec_op),
		.result_o (alu_result),
		.lt_o     (alu_lt),
		.zf_o     (alu_zf)
	);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q           <= '0;
			result_valid_o <= 1'b0;
			result_o       <= '0;
			zf_o           <= 1'b0;
			lt_o           <= 1'b0;
			res_op_q       <= ALU_ADD;
		end else begin
			result_valid_o <= instr_valid_i; // Single-cycle strobe
			if (instr_valid_i) begin
				pc_q     <= pc2;        // Two bytes per instruction
				result_o <= alu_result;
				zf_o     <= alu_zf;
				lt_o     <= alu_lt;
				res_op_q <= dec_op;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/inst_decode.sv
// Instruction decoder of the execute stage, splits a word into ALU op, register addresses and immediate
`timescale 1ns/10ps
`default_nettype none

module inst_decode (
	input  wire isa_pkg::instr_u instr_i,
	output alu_pkg::alu_op_e     op_o,
	output isa_pkg::reg_addr_t   ra_o,      // A read address
	output isa_pkg::reg_addr_t   rb_o,      // B read address
	output isa_pkg::reg_addr_t   rd_o,      // Write-back address
	output logic                 use_imm_o, // B comes from imm_o
	output alu_pkg::word_t       imm_o      // Zero-extended immediate
);
	import alu_pkg::*;
	import isa_pkg::*;

	always_comb begin
		if (instr_i.r.fmt == FMT_IMM) begin
			// Immediate view
			op_o      = alu_op_e'(instr_i.i.op);
			rd_o      = instr_i.i.rd;
			ra_o      = instr_i.i.rd;            // Destination doubles as A
			rb_o      = '0;                      // B port unused
			use_imm_o = 1'b1;
			imm_o     = word_t'(instr_i.i.imm);  // Upper byte zero
		end else begin
			// Register view, spare bits ignored
			op_o      = alu_op_e'(instr_i.r.op);
			rd_o      = instr_i.r.rd;
			ra_o      = instr_i.r.rs;
			rb_o      = instr_i.r.rt;
			use_imm_o = 1'b0;
			imm_o     = '0;
		end
	end

endmodule

`default_nettype wire

// File: hw/isa_pkg.sv
// Instruction word layout of the execute stage, imported by the decoder and the top level
`default_nettype none

package isa_pkg;

	localparam int REG_AW = 3; // Eight architectural registers
	localparam int OPC_W  = 4; // ALU operation field
	localparam int IMM_W  = 8; // Immediate field

	typedef logic [REG_AW-1:0] reg_addr_t; // Register index
	typedef logic [IMM_W-1:0]  imm_t;      // Raw immediate, zero-extended later

	typedef enum logic {
		FMT_REG = 1'b0, // rd <- rs op rt
		FMT_IMM = 1'b1  // rd <- rd op imm
	} fmt_e;

	// Register format, bit 15 down to bit 0
	typedef struct packed {
		fmt_e             fmt;   // Format select
		logic [OPC_W-1:0] op;    // ALU operation
		reg_addr_t        rd;    // Destination
		reg_addr_t        rs;    // A source
		reg_addr_t        rt;    // B source
		logic [1:0]       spare; // Ignored by decode
	} instr_reg_t;

	// Immediate format, same top fields as above
	typedef struct packed {
		fmt_e             fmt;   // Format select
		logic [OPC_W-1:0] op;    // ALU operation
		reg_addr_t        rd;    // Destination and A source
		imm_t             imm;   // Replaces B
	} instr_imm_t;

	// One 16-bit word, two readings
	typedef union packed {
		instr_reg_t r; // Register view
		instr_imm_t i; // Immediate view
	} instr_u;

endpackage

`default_nettype wire

// File: hw/reg_file.sv
// Eight-entry register file of the execute stage, two combinational reads and one clocked write
`timescale 1ns/10ps
`default_nettype none

module reg_file (
	input  wire logic               clk_i,
	input  wire logic               arst_n_i,
	input  wire logic               we_i,     // Write strobe
	input  wire isa_pkg::reg_addr_t wa_i,
	input  wire isa_pkg::reg_addr_t ra_i,
	input  wire isa_pkg::reg_addr_t rb_i,
	input  wire alu_pkg::word_t     wd_i,
	output alu_pkg::word_t          rda_o,
	output alu_pkg::word_t          rdb_o
);
	import alu_pkg::*;
	import isa_pkg::*;

	localparam int NUM_REGS = 2 ** REG_AW; // One per index value

	word_t regs [NUM_REGS];

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int k = 0; k < NUM_REGS; k++) begin
				regs[k] <= '0; // All registers start at zero
			end
		end else if (we_i) begin
			regs[wa_i] <= wd_i; // Visible to reads next cycle
		end
	end

	// Reads see the value before any write this cycle
	assign rda_o = regs[ra_i];
	assign rdb_o = regs[rb_i];

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the execute-stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module exec_core_tb -f exec_core.f -Mdir obj_dir
out=$(./obj_dir/Vexec_core_tb)
echo "$out"
echo "$out" | grep -qx "Test passed"
